// ==== sources.f ====
rtl/rv_isa_pkg.sv
rtl/core_ctrl_pkg.sv
rtl/instr_decoder.sv
rtl/core_fsm.sv
rtl/alu_unit.sv
rtl/branch_unit.sv
rtl/reg_file.sv
rtl/rv_core.sv
tests/tb_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds tb_core with Verilator, runs it into sim.log and checks the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_core -Mdir "$build_dir" -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/Vtb_core" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "All tests passed" "$log_file"; then
    echo "Result: PASS"
    exit 0
else
    echo "Result: FAIL"
    exit 1
fi

// ==== tests/tb_core.sv ====
`timescale 1ns/1ps

module tb_core;
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    localparam word_t reset_pc     = 32'h0000_1000;  // Away from zero to catch a wrong start
    localparam int    n_instr      = 2000;
    localparam int    reset_cycles = 3;
    localparam int    cycle_limit  = n_instr * 12 + reset_cycles;  // Worst case store path

    logic        clock;
    logic        reset;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic [31:0] lfsr;               // Random source state
    word_t       model_pc;
    word_t       model_regs [0:31];
    logic        store_pending;      // sw done in the model, bus write still due
    word_t       exp_adr;
    word_t       exp_dat;
    logic        in_access;          // Slave has seen the current request
    logic        ack_given;
    logic [1:0]  waits;              // Wait cycles left before ack
    logic        acc_we;             // Request as first seen, for stability
    word_t       acc_adr;
    word_t       acc_dat;
    int          instr_count;
    int          cycle_count;

    rv_core #(
        .reset_pc (reset_pc)
    ) i_dut (
        .clock  (clock),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    always #10 clock = ~clock;  // 20 ns period

    // Fibonacci LFSR, taps 32 22 2 1, stepped once per bit
    function automatic word_t rand_bits(int n);
        word_t value;
        logic  fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr  = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic word_t small_offset();
        word_t r;
        r = rand_bits(4);
        return {{26{r[3]}}, r[3:0], 2'b00};  // -32 to +28
    endfunction

    task automatic stop_on_error();
        $display("Some tests failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(string name, word_t expected, word_t actual);
        $display("FAIL time %0t %s expected %h actual %h", $time, name, expected, actual);
        stop_on_error();
    endtask

    task automatic report_error(string msg);
        $display("ERROR time %0t %s", $time, msg);
        stop_on_error();
    endtask

    task automatic write_reg(reg_idx_t rd, word_t value);
        if (rd != 5'd0) model_regs[rd] = value;  // x0 stays zero
    endtask

    // Random legal instruction, model stepped through it, encoding returned
    task automatic issue_instr(output word_t word);
        logic [3:0] kind;
        logic [1:0] sel;
        logic [2:0] f3;
        logic [6:0] opc;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        word_t      a;
        word_t      b;
        word_t      r;
        word_t      imm;
        word_t      off;
        word_t      next_pc;
        logic       taken;
        kind    = 4'(rand_bits(4));
        rd      = 5'(rand_bits(5));
        rs1     = 5'(rand_bits(5));
        rs2     = 5'(rand_bits(5));   // Also the shift amount
        r       = rand_bits(12);
        imm     = {{20{r[11]}}, r[11:0]};  // 12-bit signed immediate
        off     = small_offset();
        a       = model_regs[rs1];
        b       = model_regs[rs2];
        next_pc = model_pc + 32'd4;
        case (kind)
            4'd0: begin
                word = {7'h00, rs2, rs1, 3'd0, rd, 7'd51};  // add
                write_reg(rd, a + b);
            end
            4'd1: begin
                word = {7'h20, rs2, rs1, 3'd0, rd, 7'd51};  // sub
                write_reg(rd, a - b);
            end
            4'd2: begin
                word = {7'h00, rs2, rs1, 3'd7, rd, 7'd51};  // and
                write_reg(rd, a & b);
            end
            4'd3: begin
                word = {7'h00, rs2, rs1, 3'd2, rd, 7'd51};  // slt
                write_reg(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
            end
            4'd4: begin
                word = {imm[11:0], rs1, 3'd0, rd, 7'd19};  // addi
                write_reg(rd, a + imm);
            end
            4'd5: begin
                word = {imm[11:0], rs1, 3'd2, rd, 7'd19};  // slti
                write_reg(rd, ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0);
            end
            4'd6: begin
                word = {7'h00, rs2, rs1, 3'd1, rd, 7'd19};  // slli
                write_reg(rd, a << rs2);
            end
            4'd7: begin
                word = {7'h00, rs2, rs1, 3'd5, rd, 7'd19};  // srli
                write_reg(rd, a >> rs2);
            end
            4'd8: begin
                word = {7'h20, rs2, rs1, 3'd5, rd, 7'd19};  // srai
                write_reg(rd, word_t'($signed(a) >>> rs2));
            end
            4'd9: begin
                r    = rand_bits(20);
                word = {r[19:0], rd, 7'd55};  // lui
                write_reg(rd, {r[19:0], 12'b0});
            end
            4'd10: begin
                word    = {off[20], off[10:1], off[11], off[19:12], rd, 7'd111};  // jal
                next_pc = model_pc + off;
                write_reg(rd, model_pc + 32'd4);
            end
            4'd11: begin
                word    = {off[11:0], rs1, 3'd0, rd, 7'd103};  // jalr, target before rd write
                next_pc = (a + off) & ~32'd1;
                write_reg(rd, model_pc + 32'd4);
            end
            4'd12: begin
                sel = 2'(rand_bits(2));
                case (sel)
                    2'd0: begin
                        f3    = 3'd0;  // beq keeps its own opcode
                        opc   = 7'd99;
                        taken = (a == b);
                    end
                    2'd1: begin
                        f3    = 3'd1;
                        opc   = 7'd103;
                        taken = (a != b);
                    end
                    2'd2: begin
                        f3    = 3'd4;
                        opc   = 7'd103;
                        taken = ($signed(a) < $signed(b));
                    end
                    default: begin
                        f3    = 3'd5;
                        opc   = 7'd103;
                        taken = ($signed(a) >= $signed(b));
                    end
                endcase
                word = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc};
                if (taken) next_pc = model_pc + off;
            end
            4'd13, 4'd14: begin
                word          = {imm[11:5], rs2, rs1, 3'd2, imm[4:0], 7'd35};  // sw
                store_pending = 1'b1;
                exp_adr       = a + imm;
                exp_dat       = b;
            end
            default: begin
                r    = rand_bits(25);
                word = {r[24:0], 7'h03};  // Load opcode, not kept, acts as no-op
            end
        endcase
        model_pc = next_pc;
    endtask

    // Slave side of one clock cycle, run just after the rising edge
    task automatic serve_bus();
        word_t fetched;
        if (ack_given) begin
            assert (!wb_req.cyc && !wb_req.stb)
                else report_error("cyc or stb still high one cycle after ack");
            wb_rsp.ack = 1'b0;
            ack_given  = 1'b0;
            in_access  = 1'b0;
        end else if (wb_req.cyc && wb_req.stb) begin
            if (!in_access) begin
                in_access = 1'b1;
                acc_we    = wb_req.we;
                acc_adr   = wb_req.adr;
                acc_dat   = wb_req.dat;
                waits     = 2'(rand_bits(2));  // 0 to 3 wait cycles
                if (store_pending) begin
                    assert (wb_req.we === 1'b1)
                        else report_error("fetch seen where the store write was due");
                    assert (wb_req.adr === exp_adr)
                        else report_mismatch("wb_req.adr", exp_adr, wb_req.adr);
                    assert (wb_req.dat === exp_dat)
                        else report_mismatch("wb_req.dat", exp_dat, wb_req.dat);
                end else begin
                    assert (wb_req.we === 1'b0)
                        else report_error("bus write seen with no store instruction");
                    assert (wb_req.adr === model_pc)
                        else report_mismatch("wb_req.adr", model_pc, wb_req.adr);
                end
            end else begin
                assert (wb_req.adr === acc_adr)
                    else report_mismatch("wb_req.adr", acc_adr, wb_req.adr);
                assert (wb_req.dat === acc_dat)
                    else report_mismatch("wb_req.dat", acc_dat, wb_req.dat);
                assert (wb_req.we === acc_we)
                    else report_error("wb_req.we changed while waiting for ack");
            end
            if (waits == 2'd0) begin
                wb_rsp.ack = 1'b1;
                ack_given  = 1'b1;
                if (!acc_we) begin
                    issue_instr(fetched);  // Model runs at fetch ack
                    wb_rsp.dat = fetched;
                    instr_count++;
                end else begin
                    store_pending = 1'b0;
                end
            end else begin
                waits--;
            end
        end
    endtask

    initial begin
        clock         = 1'b0;
        reset         = 1'b1;
        wb_rsp        = '0;
        lfsr          = 32'd76768;
        model_pc      = reset_pc;
        store_pending = 1'b0;
        exp_adr       = '0;
        exp_dat       = '0;
        in_access     = 1'b0;
        ack_given     = 1'b0;
        waits         = 2'd0;
        instr_count   = 0;
        cycle_count   = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (reset_cycles) begin
            @(posedge clock);
            #2;
            assert (!wb_req.cyc && !wb_req.stb) else report_error("cyc or stb high during reset");
        end
        reset = 1'b0;
        while (instr_count < n_instr || store_pending) begin
            @(posedge clock);
            #2;  // Outputs settled, inputs change away from the edge
            cycle_count++;
            assert (cycle_count <= cycle_limit)
                else report_error("timeout, the core stopped completing bus accesses");
            serve_bus();
        end
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== rtl/rv_core.sv ====
`timescale 1ns/1ps

module rv_core #(
    parameter rv_isa_pkg::word_t reset_pc = 32'h0000_0000  // First fetch address
) (
    input  logic                   clock,
    input  logic                   reset,
    output core_ctrl_pkg::wb_req_t wb_req,
    input  core_ctrl_pkg::wb_rsp_t wb_rsp
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    instr_t instr;       // Instruction register
    ctrl_t  ctrl;
    word_t  imm;
    word_t  pc;
    word_t  rs1_val;
    word_t  rs2_val;
    word_t  alu_result;  // Also the store address
    word_t  next_pc;
    word_t  link;
    logic   rf_write;

    instr_decoder i_decoder (
        .instr (instr),
        .ctrl  (ctrl),
        .imm   (imm)
    );

    core_fsm #(
        .reset_pc (reset_pc)
    ) i_fsm (
        .clock      (clock),
        .reset      (reset),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .ctrl       (ctrl),
        .next_pc    (next_pc),
        .store_addr (alu_result),
        .store_data (rs2_val),     // sw writes rs2
        .instr      (instr),
        .pc         (pc),
        .rf_write   (rf_write)
    );

    alu_unit i_alu (
        .ctrl       (ctrl),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .imm        (imm),
        .alu_result (alu_result)
    );

    branch_unit i_branch (
        .ctrl    (ctrl),
        .pc      (pc),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .imm     (imm),
        .next_pc (next_pc),
        .link    (link)
    );

    reg_file i_regs (
        .clock      (clock),
        .reset      (reset),
        .instr      (instr),
        .ctrl       (ctrl),
        .rf_write   (rf_write),
        .alu_result (alu_result),
        .link       (link),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val)
    );

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                 clock,
    input  logic                 reset,
    input  rv_isa_pkg::instr_t   instr,
    input  core_ctrl_pkg::ctrl_t ctrl,
    input  logic                 rf_write,
    input  rv_isa_pkg::word_t    alu_result,
    input  rv_isa_pkg::word_t    link,
    output rv_isa_pkg::word_t    rs1_val,
    output rv_isa_pkg::word_t    rs2_val
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    word_t    regs [1:31];  // x0 is not stored
    reg_idx_t rs1_idx;
    word_t    wb_data;      // Result captured at end of execute
    logic     wr_en;

    assign rs1_idx = ctrl.rs1_zero ? reg_idx_t'(0) : instr.rs1;  // lui reads x0
    assign wr_en   = rf_write && (ctrl.wb_src != wb_none) && (instr.rd != '0);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[instr.rd] <= wb_data;
        end
    end

    // Read ports and write-back select, stable from execute on
    always_ff @(posedge clock) begin
        rs1_val <= (rs1_idx == '0) ? '0 : regs[rs1_idx];
        rs2_val <= (instr.rs2 == '0) ? '0 : regs[instr.rs2];
        wb_data <= (ctrl.wb_src == wb_link) ? link : alu_result;
    end

endmodule

// ==== rtl/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
    input  core_ctrl_pkg::ctrl_t ctrl,
    input  rv_isa_pkg::word_t    pc,
    input  rv_isa_pkg::word_t    rs1_val,
    input  rv_isa_pkg::word_t    rs2_val,
    input  rv_isa_pkg::word_t    imm,
    output rv_isa_pkg::word_t    next_pc,
    output rv_isa_pkg::word_t    link
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic  taken;     // PC-relative redirect
    word_t pc_plus4;
    word_t jalr_sum;  // rs1 + imm before bit 0 is cleared

    assign pc_plus4 = pc + 32'd4;
    assign jalr_sum = rs1_val + imm;
    assign link     = pc_plus4;

    always_comb begin
        case (ctrl.branch_op)
            br_eq:   taken = (rs1_val == rs2_val);
            br_ne:   taken = (rs1_val != rs2_val);
            br_lt:   taken = ($signed(rs1_val) < $signed(rs2_val));
            br_ge:   taken = ($signed(rs1_val) >= $signed(rs2_val));
            br_jal:  taken = 1'b1;
            default: taken = 1'b0;  // br_none, jalr handled apart
        endcase
    end

    always_comb begin
        if (ctrl.branch_op == br_jalr) begin
            next_pc = {jalr_sum[xlen-1:1], 1'b0};
        end else if (taken) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc_plus4;  // Not taken, no-op or ALU op
        end
    end

endmodule

// ==== rtl/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit (
    input  core_ctrl_pkg::ctrl_t ctrl,
    input  rv_isa_pkg::word_t    rs1_val,
    input  rv_isa_pkg::word_t    rs2_val,
    input  rv_isa_pkg::word_t    imm,
    output rv_isa_pkg::word_t    alu_result
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    word_t      op_b;   // rs2 or immediate
    logic [4:0] shamt;  // Shift by low 5 bits
    logic       lt;     // Signed rs1 < op_b

    assign op_b  = ctrl.use_imm ? imm : rs2_val;
    assign shamt = op_b[4:0];
    assign lt    = $signed(rs1_val) < $signed(op_b);

    always_comb begin
        case (ctrl.alu_op)
            alu_add: alu_result = rs1_val + op_b;  // Also store address and lui
            alu_sub: alu_result = rs1_val - op_b;
            alu_and: alu_result = rs1_val & op_b;
            alu_slt: alu_result = {{(xlen - 1){1'b0}}, lt};
            alu_sll: alu_result = rs1_val << shamt;
            alu_srl: alu_result = rs1_val >> shamt;
            alu_sra: alu_result = word_t'($signed(rs1_val) >>> shamt);  // Sign fill
            default: alu_result = rs1_val + op_b;
        endcase
    end

endmodule

// ==== rtl/core_fsm.sv ====
`timescale 1ns/1ps

module core_fsm #(
    parameter rv_isa_pkg::word_t reset_pc = '0
) (
    input  logic                   clock,
    input  logic                   reset,
    output core_ctrl_pkg::wb_req_t wb_req,
    input  core_ctrl_pkg::wb_rsp_t wb_rsp,
    input  core_ctrl_pkg::ctrl_t   ctrl,
    input  rv_isa_pkg::word_t      next_pc,
    input  rv_isa_pkg::word_t      store_addr,
    input  rv_isa_pkg::word_t      store_data,
    output rv_isa_pkg::instr_t     instr,
    output rv_isa_pkg::word_t      pc,
    output logic                   rf_write
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    state_e state;
    logic   req_cyc;    // Access in flight, drives cyc and stb
    logic   req_we;
    word_t  req_adr;
    word_t  req_dat;
    word_t  next_pc_q;  // Target captured in execute
    logic   bus_done;   // Ack of the open access

    assign bus_done = req_cyc && wb_rsp.ack;
    assign rf_write = (state == st_writeback);  // Register file qualifies rd and wb_src

    // Classic single access, stb follows cyc
    assign wb_req = '{cyc: req_cyc, stb: req_cyc, we: req_we, adr: req_adr, dat: req_dat};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state   <= st_fetch;
            req_cyc <= 1'b0;
            req_we  <= 1'b0;
            pc      <= reset_pc;
        end else begin
            case (state)
                st_fetch: begin
                    if (!req_cyc) begin
                        req_cyc <= 1'b1;  // After reset or a store
                    end else if (bus_done) begin
                        req_cyc <= 1'b0;
                        state   <= st_decode;
                    end
                end
                st_decode: state <= st_execute;
                st_execute: begin
                    if (ctrl.is_store) begin
                        req_cyc <= 1'b1;  // Write request goes out with the state
                        req_we  <= 1'b1;
                        state   <= st_store;
                    end else begin
                        state <= st_writeback;
                    end
                end
                st_writeback: begin
                    pc      <= next_pc_q;
                    req_cyc <= 1'b1;  // Next fetch starts right away
                    state   <= st_fetch;
                end
                st_store: begin
                    if (bus_done) begin
                        req_cyc <= 1'b0;  // One idle cycle before the next fetch
                        req_we  <= 1'b0;
                        pc      <= next_pc_q;
                        state   <= st_fetch;
                    end
                end
                default: state <= st_fetch;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        case (state)
            st_fetch: begin
                if (!req_cyc) req_adr <= pc;
                else if (bus_done) instr <= instr_t'(wb_rsp.dat);  // IR loads on ack edge
            end
            st_execute: begin
                next_pc_q <= next_pc;
                req_adr   <= store_addr;  // Only used when a store follows
                req_dat   <= store_data;
            end
            st_writeback: req_adr <= next_pc_q;
            default: ;
        endcase
    end

endmodule

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
    input  rv_isa_pkg::instr_t   instr,
    output core_ctrl_pkg::ctrl_t ctrl,
    output rv_isa_pkg::word_t    imm
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    word_t raw;    // Flat view for immediate slicing
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    // ALU instruction writing its result to rd
    function automatic ctrl_t alu_ctrl(alu_op_e op, logic with_imm);
        ctrl_t c;
        c         = '0;
        c.alu_op  = op;
        c.use_imm = with_imm;
        c.wb_src  = wb_alu;
        return c;
    endfunction

    assign raw   = instr;
    assign imm_i = {{20{raw[31]}}, raw[31:20]};
    assign imm_s = {{20{raw[31]}}, raw[31:25], raw[11:7]};
    assign imm_b = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
    assign imm_u = {raw[31:12], 12'b0};  // Low 12 bits zero
    assign imm_j = {{11{raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};

    always_comb begin
        ctrl = '0;  // Unknown code falls through as a no-op
        imm  = imm_i;
        case (instr.opcode)
            op_reg: begin
                if (instr.funct7 == funct7_base) begin
                    case (instr.funct3)
                        f3_add_beq: ctrl = alu_ctrl(alu_add, 1'b0);
                        f3_and:     ctrl = alu_ctrl(alu_and, 1'b0);
                        f3_slt_sw:  ctrl = alu_ctrl(alu_slt, 1'b0);
                        default:    ctrl = '0;
                    endcase
                end else if (instr.funct7 == funct7_alt && instr.funct3 == f3_add_beq) begin
                    ctrl = alu_ctrl(alu_sub, 1'b0);
                end
            end
            op_imm: begin
                case (instr.funct3)
                    f3_add_beq: ctrl = alu_ctrl(alu_add, 1'b1);  // addi, nop included
                    f3_slt_sw:  ctrl = alu_ctrl(alu_slt, 1'b1);
                    f3_sll_bne: if (instr.funct7 == funct7_base) ctrl = alu_ctrl(alu_sll, 1'b1);
                    f3_sr_bge: begin
                        if (instr.funct7 == funct7_base) ctrl = alu_ctrl(alu_srl, 1'b1);
                        else if (instr.funct7 == funct7_alt) ctrl = alu_ctrl(alu_sra, 1'b1);
                    end
                    default:    ctrl = '0;
                endcase
            end
            op_lui: begin
                ctrl          = alu_ctrl(alu_add, 1'b1);  // 0 + upper immediate
                ctrl.rs1_zero = 1'b1;
                imm           = imm_u;
            end
            op_jal: begin
                ctrl.branch_op = br_jal;
                ctrl.wb_src    = wb_link;
                imm            = imm_j;
            end
            op_branch: begin
                imm = imm_b;
                if (instr.funct3 == f3_add_beq) ctrl.branch_op = br_eq;
            end
            op_jalr_branch: begin
                imm = imm_b;
                case (instr.funct3)
                    f3_add_beq: begin
                        ctrl.branch_op = br_jalr;
                        ctrl.wb_src    = wb_link;
                        imm            = imm_i;  // Offset from rs1
                    end
                    f3_sll_bne: ctrl.branch_op = br_ne;
                    f3_blt:     ctrl.branch_op = br_lt;
                    f3_sr_bge:  ctrl.branch_op = br_ge;
                    default:    ctrl = '0;
                endcase
            end
            op_store: begin
                imm = imm_s;
                if (instr.funct3 == f3_slt_sw) begin
                    ctrl          = alu_ctrl(alu_add, 1'b1);  // Address rs1 + imm
                    ctrl.wb_src   = wb_none;
                    ctrl.is_store = 1'b1;
                end
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// ==== rtl/core_ctrl_pkg.sv ====
package core_ctrl_pkg;

    typedef enum logic [2:0] {
        st_fetch,      // Read instruction at PC
        st_decode,     // Register file read
        st_execute,    // ALU and branch result captured
        st_writeback,  // rd write and PC update
        st_store       // Data write on the bus
    } state_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_slt,  // Signed compare
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none,  // Fall through to PC + 4
        br_eq,
        br_ne,
        br_lt,    // Signed
        br_ge,    // Signed
        br_jal,
        br_jalr
    } branch_op_e;

    typedef enum logic [1:0] {
        wb_none,  // No rd write
        wb_alu,
        wb_link   // PC + 4 of a jump
    } wb_src_e;

    // All-zero value is the inactive no-op
    typedef struct packed {
        alu_op_e    alu_op;
        branch_op_e branch_op;
        wb_src_e    wb_src;
        logic       use_imm;   // Operand B from immediate
        logic       is_store;
        logic       rs1_zero;  // Read x0 in place of rs1, for lui
    } ctrl_t;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        rv_isa_pkg::word_t adr;
        rv_isa_pkg::word_t dat;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        rv_isa_pkg::word_t dat;
    } wb_rsp_t;

endpackage

// ==== rtl/rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int xlen = 32;  // Data and address width

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;  // x0 to x31

    // Major opcodes, with beq apart from the other branches
    typedef enum logic [6:0] {
        op_reg         = 7'd51,   // R-type ALU
        op_imm         = 7'd19,   // I-type ALU and shifts
        op_lui         = 7'd55,   // Upper immediate
        op_jal         = 7'd111,  // Jump and link
        op_jalr_branch = 7'd103,  // jalr, bne, blt, bge
        op_branch      = 7'd99,   // beq only
        op_store       = 7'd35    // sw
    } opcode_e;

    typedef enum logic [2:0] {
        f3_add_beq = 3'd0,  // add, sub, addi, beq, jalr
        f3_sll_bne = 3'd1,  // slli or bne
        f3_slt_sw  = 3'd2,  // slt, slti or sw
        f3_blt     = 3'd4,  // blt
        f3_sr_bge  = 3'd5,  // srli, srai or bge
        f3_and     = 3'd7   // and
    } funct3_e;

    localparam logic [6:0] funct7_base = 7'h00;  // add, srl and the rest
    localparam logic [6:0] funct7_alt  = 7'h20;  // sub, srai

    // Field layout of a 32-bit instruction word
    typedef struct packed {
        logic [6:0] funct7;  // Also the upper immediate bits
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        funct3_e    funct3;
        reg_idx_t   rd;
        opcode_e    opcode;
    } instr_t;

endpackage
